// File: hdl/pat_pkg.sv
package pat_pkg;

	// ========================================
	// widths and basic types
	// ========================================
	localparam int d_width = 8; // data path width
	localparam int reg_count = 8; // register file depth

	typedef logic [d_width-1:0] data_t;
	typedef logic [2:0] reg_adr_t; // one of reg_count registers

	// 17-bit instruction word, msb first
	typedef struct packed {
		reg_adr_t rn; // source and destination register
		logic [1:0] cond; // branch condition, only BF looks at it
		logic [3:0] op_i8; // primary opcode
		data_t imm8; // immediate, or i3/i0 opcode + imm3
	} instr_t;

	// ========================================
	// opcodes
	// ========================================
	// i8 space
	localparam logic [3:0] op_ori = 4'd0;
	localparam logic [3:0] op_orr = 4'd1;
	localparam logic [3:0] op_andi = 4'd2;
	localparam logic [3:0] op_andr = 4'd3;
	localparam logic [3:0] op_addi = 4'd4;
	localparam logic [3:0] op_addr = 4'd5;
	localparam logic [3:0] op_subi = 4'd6;
	localparam logic [3:0] op_subr = 4'd7;
	localparam logic [3:0] op_ldi = 4'd8;
	localparam logic [3:0] op_bf = 4'd13;
	localparam logic [3:0] op_prefix = 4'd15; // escape to the next space

	// i3 space, imm8[7:4]
	localparam logic [3:0] op_shlzi = 4'd0;
	localparam logic [3:0] op_shlzr = 4'd1;
	localparam logic [3:0] op_shloi = 4'd2;
	localparam logic [3:0] op_shlor = 4'd3;
	localparam logic [3:0] op_shrzi = 4'd4;
	localparam logic [3:0] op_shrzr = 4'd5;
	localparam logic [3:0] op_out = 4'd11;

	// i0 space, imm8[3:0]
	localparam logic [3:0] op_not = 4'd0;
	localparam logic [3:0] op_test = 4'd2;
	localparam logic [3:0] op_nop = 4'd15;

	// branch conditions
	localparam logic [1:0] cond_z = 2'd0; // zero
	localparam logic [1:0] cond_nz = 2'd1; // not zero
	localparam logic [1:0] cond_n = 2'd2; // negative
	localparam logic [1:0] cond_al = 2'd3; // always

	localparam instr_t instr_nop = '1; // all three prefixes, i0 code 15
	localparam int shadow_len = 2; // instructions dropped after a taken branch

	// nine functions, so the code needs four bits
	typedef enum logic [3:0] {
		alu_pass_b, alu_or, alu_and, alu_add, alu_sub,
		alu_not, alu_shl_zero, alu_shl_one, alu_shr_zero
	} alu_op_t;

endpackage

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
	input pat_pkg::alu_op_t i_op,
	input pat_pkg::data_t i_a, // reg[rn]
	input pat_pkg::data_t i_b, // immediate, reg[imm3] or shift amount
	output pat_pkg::data_t o_y
);
	import pat_pkg::*;

	logic [2:0] shift_n; // 1 to 4 places

	assign shift_n = {1'b0, i_b[1:0]} + 3'd1;

	// ========================================
	// function select
	// ========================================
	always_comb
	begin
		case (i_op)
			alu_pass_b: o_y = i_b; // ldi
			alu_or: o_y = i_a | i_b;
			alu_and: o_y = i_a & i_b;
			alu_add: o_y = i_a + i_b; // wraps mod 256
			alu_sub: o_y = i_a - i_b;
			alu_not: o_y = ~i_a;
			alu_shl_zero: o_y = i_a << shift_n;
			// shift the inverse in zeros, invert back, so the low bits come out as ones
			alu_shl_one: o_y = ~(~i_a << shift_n);
			alu_shr_zero: o_y = i_a >> shift_n;
			default: o_y = i_b; // spare codes
		endcase
	end

endmodule

// File: hdl/reg_file.sv
`timescale 1ns/1ps

module reg_file (
	input logic clk,
	input pat_pkg::reg_adr_t i_rd_adr_a,
	input pat_pkg::reg_adr_t i_rd_adr_b,
	input logic i_write,
	input pat_pkg::reg_adr_t i_wr_adr,
	input pat_pkg::data_t i_wr_data,
	output pat_pkg::data_t o_rd_a,
	output pat_pkg::data_t o_rd_b
);
	import pat_pkg::*;

	data_t regs [reg_count];

	// async read where a write in flight to the same index wins
	assign o_rd_a = (i_write && (i_wr_adr == i_rd_adr_a)) ? i_wr_data : regs[i_rd_adr_a];
	assign o_rd_b = (i_write && (i_wr_adr == i_rd_adr_b)) ? i_wr_data : regs[i_rd_adr_b];

	always_ff @(posedge clk)
	begin
		if (i_write)
			regs[i_wr_adr] <= i_wr_data;
	end

endmodule

// File: hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
	parameter int i_adr_width = 10
) (
	input logic clk,
	input logic reset,
	input pat_pkg::instr_t i_instr, // word at o_pc, same cycle
	input logic i_redirect, // taken branch in execute
	input logic [i_adr_width-1:0] i_target,
	output logic [i_adr_width-1:0] o_pc,
	output pat_pkg::instr_t o_instr,
	output logic [i_adr_width-1:0] o_instr_pc
);
	import pat_pkg::*;

	// program counter
	always_ff @(posedge clk)
	begin
		if (reset)
			o_pc <= '0;
		else if (i_redirect)
			o_pc <= i_target; // target shows on o_pc next cycle
		else
			o_pc <= o_pc + 1'b1;
	end

	// fetch register, every word moves on
	always_ff @(posedge clk)
	begin
		if (reset)
			o_instr <= instr_nop;
		else
			o_instr <= i_instr;
		o_instr_pc <= o_pc; // address the word came from
	end

endmodule

// File: hdl/decode_stage.sv
`timescale 1ns/1ps

module decode_stage #(
	parameter int i_adr_width = 10
) (
	input logic clk,
	input logic reset,
	input pat_pkg::instr_t i_instr,
	input logic [i_adr_width-1:0] i_instr_pc,
	input pat_pkg::data_t i_rd_a, // reg[rn], already bypassed
	input pat_pkg::data_t i_rd_b, // reg[imm3]
	output pat_pkg::reg_adr_t o_rd_adr_a,
	output pat_pkg::reg_adr_t o_rd_adr_b,
	output pat_pkg::alu_op_t o_alu_op,
	output pat_pkg::data_t o_opnd_a,
	output pat_pkg::data_t o_opnd_b,
	output pat_pkg::reg_adr_t o_dest,
	output logic o_write,
	output logic o_test,
	output logic o_out,
	output logic o_branch,
	output logic [1:0] o_cond,
	output logic [i_adr_width-1:0] o_target
);
	import pat_pkg::*;

	logic [3:0] op_i3; // meaningful under the i8 prefix only
	logic [3:0] op_i0; // needs the i3 prefix as well
	logic [2:0] imm3; // second register or shift amount
	logic is_i8;
	logic is_i3;
	logic is_i0;
	alu_op_t alu_op_d;
	data_t opnd_b_d;
	logic write_d;
	logic test_d;
	logic out_d;
	logic branch_d;
	logic [i_adr_width-1:0] target_d;

	// ========================================
	// field split and prefix chain
	// ========================================
	assign op_i3 = i_instr.imm8[7:4];
	assign op_i0 = i_instr.imm8[3:0];
	assign imm3 = i_instr.imm8[2:0];

	assign is_i8 = (i_instr.op_i8 != op_prefix);
	assign is_i3 = !is_i8 && (op_i3 != op_prefix);
	assign is_i0 = !is_i8 && (op_i3 == op_prefix);

	assign o_rd_adr_a = i_instr.rn;
	assign o_rd_adr_b = imm3;

	// branch target relative to the BF word itself
	assign target_d = i_instr_pc +
		{{(i_adr_width-d_width){i_instr.imm8[d_width-1]}}, i_instr.imm8};

	// ========================================
	// classify and pick operand b
	// ========================================
	always_comb
	begin
		alu_op_d = alu_pass_b;
		opnd_b_d = i_instr.imm8; // imm8 unless a form below says otherwise
		write_d = 1'b0;
		test_d = 1'b0;
		out_d = 1'b0;
		branch_d = 1'b0;
		if (is_i8)
		begin
			case (i_instr.op_i8)
				op_ori, op_orr: alu_op_d = alu_or;
				op_andi, op_andr: alu_op_d = alu_and;
				op_addi, op_addr: alu_op_d = alu_add;
				op_subi, op_subr: alu_op_d = alu_sub;
				op_ldi: alu_op_d = alu_pass_b; // b = imm8
				op_bf: branch_d = 1'b1;
				default: alu_op_d = alu_pass_b; // unused codes run as nop
			endcase
			write_d = (i_instr.op_i8 <= op_ldi); // alu group and ldi write rn
			if (i_instr.op_i8[0] && (i_instr.op_i8 < op_ldi))
				opnd_b_d = i_rd_b; // odd alu codes are register forms
		end
		else if (is_i3)
		begin
			case (op_i3)
				op_shlzi, op_shlzr: alu_op_d = alu_shl_zero;
				op_shloi, op_shlor: alu_op_d = alu_shl_one;
				op_shrzi, op_shrzr: alu_op_d = alu_shr_zero;
				op_out: out_d = 1'b1; // value is reg[rn]
				default: alu_op_d = alu_pass_b;
			endcase
			write_d = (op_i3 <= op_shrzr); // shifts only
			if (op_i3[0])
				opnd_b_d = {{(d_width-2){1'b0}}, i_rd_b[1:0]}; // amount from a register
			else
				opnd_b_d = {{(d_width-3){1'b0}}, imm3};
		end
		else if (is_i0)
		begin
			case (op_i0)
				op_not: alu_op_d = alu_not;
				op_test: test_d = 1'b1;
				default: alu_op_d = alu_pass_b; // op_nop and spare codes
			endcase
			write_d = (op_i0 == op_not);
		end
	end

	// decode register, control cleared to a nop on reset
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			o_write <= 1'b0;
			o_test <= 1'b0;
			o_out <= 1'b0;
			o_branch <= 1'b0;
		end
		else
		begin
			o_write <= write_d;
			o_test <= test_d;
			o_out <= out_d;
			o_branch <= branch_d;
		end
		o_alu_op <= alu_op_d;
		o_opnd_a <= i_rd_a;
		o_opnd_b <= opnd_b_d;
		o_dest <= i_instr.rn;
		o_cond <= i_instr.cond;
		o_target <= target_d;
	end

endmodule

// File: hdl/execute_stage.sv
`timescale 1ns/1ps

module execute_stage #(
	parameter int i_adr_width = 10
) (
	input logic clk,
	input logic reset,
	input pat_pkg::alu_op_t i_alu_op,
	input pat_pkg::data_t i_opnd_a,
	input pat_pkg::data_t i_opnd_b,
	input pat_pkg::reg_adr_t i_dest,
	input logic i_write,
	input logic i_test,
	input logic i_out,
	input logic i_branch,
	input logic [1:0] i_cond,
	input logic [i_adr_width-1:0] i_target,
	output logic o_wr,
	output pat_pkg::reg_adr_t o_wr_adr,
	output pat_pkg::data_t o_wr_data,
	output logic o_redirect, // loads the pc this cycle
	output logic [i_adr_width-1:0] o_target_q,
	output pat_pkg::data_t o_out,
	output logic o_out_strobe,
	output logic o_jump
);
	import pat_pkg::*;

	localparam int shadow_w = $clog2(shadow_len + 1);

	data_t alu_y;
	logic z_flag;
	logic n_flag;
	logic [shadow_w-1:0] shadow_cnt; // words still to drop
	logic commit_ok;
	logic cond_true;
	logic take_branch;

	alu u_alu (
		.i_op(i_alu_op),
		.i_a(i_opnd_a),
		.i_b(i_opnd_b),
		.o_y(alu_y)
	);

	// ========================================
	// condition and commit
	// ========================================
	always_comb
	begin
		case (i_cond)
			cond_z: cond_true = z_flag;
			cond_nz: cond_true = !z_flag; // not zero looks at z
			cond_n: cond_true = n_flag;
			default: cond_true = 1'b1; // cond_al
		endcase
	end

	assign commit_ok = (shadow_cnt == '0); // shadow words never commit
	assign take_branch = commit_ok && i_branch && cond_true;

	assign o_wr = commit_ok && i_write;
	assign o_wr_adr = i_dest;
	assign o_wr_data = alu_y; // also feeds the read bypass
	assign o_redirect = take_branch;
	assign o_target_q = i_target;

	// flags, shadow counter and output port
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			z_flag <= 1'b0;
			n_flag <= 1'b0;
			shadow_cnt <= '0;
			o_jump <= 1'b0;
			o_out_strobe <= 1'b0;
			o_out <= '0;
		end
		else
		begin
			o_jump <= take_branch; // pc already holds the target then
			o_out_strobe <= commit_ok && i_out;
			if (commit_ok && i_out)
				o_out <= i_opnd_a; // port 0 holds until the next OUT
			if (commit_ok && i_test)
			begin
				z_flag <= (i_opnd_a == '0);
				n_flag <= i_opnd_a[d_width-1];
			end
			if (take_branch)
				shadow_cnt <= shadow_w'(shadow_len);
			else if (shadow_cnt != '0)
				shadow_cnt <= shadow_cnt - 1'b1;
		end
	end

endmodule

// File: hdl/pat_core.sv
`timescale 1ns/1ps

module pat_core #(
	parameter int i_adr_width = 10 // pc width
) (
	input logic clk,
	input logic reset,
	input pat_pkg::instr_t i_instr, // word at o_pc
	output logic [i_adr_width-1:0] o_pc,
	output logic o_jump,
	output pat_pkg::data_t o_out,
	output logic o_out_strobe
);
	import pat_pkg::*;

	// fetch to decode
	instr_t fet_instr;
	logic [i_adr_width-1:0] fet_pc;

	// decode and register file
	reg_adr_t rd_adr_a;
	reg_adr_t rd_adr_b;
	data_t rd_a;
	data_t rd_b;

	// decode to execute
	alu_op_t dec_alu_op;
	data_t dec_opnd_a;
	data_t dec_opnd_b;
	reg_adr_t dec_dest;
	logic dec_write;
	logic dec_test;
	logic dec_out;
	logic dec_branch;
	logic [1:0] dec_cond;
	logic [i_adr_width-1:0] dec_target;

	// execute back to fetch and the register file
	logic ex_wr;
	reg_adr_t ex_wr_adr;
	data_t ex_wr_data;
	logic ex_redirect;
	logic [i_adr_width-1:0] ex_target;

	// ========================================
	// pipeline
	// ========================================
	fetch_stage #(
		.i_adr_width(i_adr_width)
	) u_fetch (
		.clk(clk),
		.reset(reset),
		.i_instr(i_instr),
		.i_redirect(ex_redirect),
		.i_target(ex_target),
		.o_pc(o_pc),
		.o_instr(fet_instr),
		.o_instr_pc(fet_pc)
	);

	decode_stage #(
		.i_adr_width(i_adr_width)
	) u_decode (
		.clk(clk),
		.reset(reset),
		.i_instr(fet_instr),
		.i_instr_pc(fet_pc),
		.i_rd_a(rd_a),
		.i_rd_b(rd_b),
		.o_rd_adr_a(rd_adr_a),
		.o_rd_adr_b(rd_adr_b),
		.o_alu_op(dec_alu_op),
		.o_opnd_a(dec_opnd_a),
		.o_opnd_b(dec_opnd_b),
		.o_dest(dec_dest),
		.o_write(dec_write),
		.o_test(dec_test),
		.o_out(dec_out),
		.o_branch(dec_branch),
		.o_cond(dec_cond),
		.o_target(dec_target)
	);

	reg_file u_regs (
		.clk(clk),
		.i_rd_adr_a(rd_adr_a),
		.i_rd_adr_b(rd_adr_b),
		.i_write(ex_wr),
		.i_wr_adr(ex_wr_adr),
		.i_wr_data(ex_wr_data),
		.o_rd_a(rd_a),
		.o_rd_b(rd_b)
	);

	execute_stage #(
		.i_adr_width(i_adr_width)
	) u_execute (
		.clk(clk),
		.reset(reset),
		.i_alu_op(dec_alu_op),
		.i_opnd_a(dec_opnd_a),
		.i_opnd_b(dec_opnd_b),
		.i_dest(dec_dest),
		.i_write(dec_write),
		.i_test(dec_test),
		.i_out(dec_out),
		.i_branch(dec_branch),
		.i_cond(dec_cond),
		.i_target(dec_target),
		.o_wr(ex_wr),
		.o_wr_adr(ex_wr_adr),
		.o_wr_data(ex_wr_data),
		.o_redirect(ex_redirect),
		.o_target_q(ex_target),
		.o_out(o_out),
		.o_out_strobe(o_out_strobe),
		.o_jump(o_jump)
	);

endmodule

// File: dv/tb_clock.sv
`timescale 1ns/1ps

module tb_clock #(
	parameter int period = 100
) (
	input logic i_restart, // sampled on the rising edge
	output logic o_clk,
	output logic o_reset
);
	int hold_cnt; // reset cycles still to go
	logic req;

	initial
	begin
		o_clk = 1'b0;
		forever
			#(period / 2) o_clk = ~o_clk;
	end

	// reset is high for 3 rising edges, at start and after each restart
	initial
	begin
		o_reset = 1'b1;
		hold_cnt = 2;
		forever
		begin
			@(posedge o_clk);
			req = i_restart;
			#1;
			if (req)
				hold_cnt = 3;
			o_reset = (hold_cnt > 0);
			if (hold_cnt > 0)
				hold_cnt--;
		end
	end

endmodule

// File: dv/pat_core_tb.sv
`timescale 1ns/1ps

module pat_core_tb;
	import pat_pkg::*;

	localparam int adr_w = 10;
	localparam int period = 100;

	logic clk;
	logic reset;
	logic restart;
	instr_t i_instr;
	logic [adr_w-1:0] o_pc;
	logic o_jump;
	data_t o_out;
	logic o_out_strobe;

	logic [16:0] prog [1 << adr_w]; // program store seen by the DUT
	logic [16:0] pgm [$]; // program under construction
	data_t exp_out [$]; // expected OUT values, in order
	logic [adr_w-1:0] exp_tgt [$]; // expected branch targets
	data_t exp_v;
	logic [adr_w-1:0] exp_t;
	bit active; // checker armed
	int errors;
	int tests_run;
	int tests_failed;
	longint budget; // watchdog limit in cycles
	longint cycles;

	tb_clock #(.period(period)) u_clock (
		.i_restart(restart),
		.o_clk(clk),
		.o_reset(reset)
	);

	pat_core #(.i_adr_width(adr_w)) DUT (
		.clk(clk),
		.reset(reset),
		.i_instr(i_instr),
		.o_pc(o_pc),
		.o_jump(o_jump),
		.o_out(o_out),
		.o_out_strobe(o_out_strobe)
	);

	// ========================================
	// instruction encoders
	// ========================================
	function automatic logic [16:0] enc_i8(input logic [3:0] op, input logic [2:0] rn,
		input logic [7:0] imm);
		return {rn, 2'b00, op, imm};
	endfunction

	function automatic logic [16:0] enc_i3(input logic [3:0] op, input logic [2:0] rn,
		input logic [2:0] s);
		return {rn, 2'b00, 4'hf, op, 1'b0, s};
	endfunction

	function automatic logic [16:0] enc_i0(input logic [3:0] op, input logic [2:0] rn);
		return {rn, 2'b00, 4'hf, 4'hf, op};
	endfunction

	function automatic logic [16:0] enc_bf(input logic [1:0] cnd, input logic [7:0] off);
		return {3'b000, cnd, op_bf, off};
	endfunction

	// i0 nop with the free rn and cond bits folded from the address
	function automatic logic [16:0] fill_word(input int a);
		logic [9:0] adr;
		adr = a[9:0];
		return {adr[2:0] ^ adr[5:3] ^ adr[8:6] ^ {2'b00, adr[9]}, adr[1:0] ^ adr[3:2], 12'hfff};
	endfunction

	// ========================================
	// ISA model running the program in zero time
	// ========================================
	task automatic model_run(output int steps);
		data_t r [8];
		logic z;
		logic n;
		logic [adr_w-1:0] pc;
		logic [adr_w-1:0] npc;
		logic [16:0] w;
		logic [2:0] rn;
		logic [3:0] op;
		logic [3:0] o3;
		data_t im;
		data_t b;
		int amt;
		bit halt;
		bit take;
		exp_out.delete();
		exp_tgt.delete();
		foreach (r[i])
			r[i] = '0;
		z = 1'b0;
		n = 1'b0;
		pc = '0;
		halt = 1'b0;
		steps = 0;
		while (!halt && steps < 2000)
		begin
			w = prog[pc];
			rn = w[16:14];
			op = w[11:8];
			im = w[7:0];
			o3 = im[7:4];
			npc = pc + 1'b1;
			steps++;
			if (op != op_prefix)
			begin
				b = op[0] ? r[im[2:0]] : im; // odd codes take a register
				case (op)
					op_ori, op_orr: r[rn] = r[rn] | b;
					op_andi, op_andr: r[rn] = r[rn] & b;
					op_addi, op_addr: r[rn] = r[rn] + b;
					op_subi, op_subr: r[rn] = r[rn] - b;
					op_ldi: r[rn] = im;
					op_bf:
					begin
						case (w[13:12])
							cond_z: take = z;
							cond_nz: take = !z;
							cond_n: take = n;
							default: take = 1'b1;
						endcase
						if (take)
						begin
							npc = pc + {{(adr_w-8){im[7]}}, im};
							exp_tgt.push_back(npc);
							halt = (im == 8'h00); // branch to self ends the program
						end
					end
					default: ;
				endcase
			end
			else if (o3 != op_prefix)
			begin
				b = o3[0] ? r[im[2:0]] : {5'b0, im[2:0]};
				amt = int'(b[1:0]) + 1;
				case (o3)
					op_shlzi, op_shlzr: r[rn] = r[rn] << amt;
					op_shloi, op_shlor: r[rn] = (r[rn] << amt) | data_t'((1 << amt) - 1);
					op_shrzi, op_shrzr: r[rn] = r[rn] >> amt;
					op_out: exp_out.push_back(r[rn]);
					default: ;
				endcase
			end
			else if (im[3:0] == op_not)
				r[rn] = ~r[rn];
			else if (im[3:0] == op_test)
			begin
				z = (r[rn] == '0);
				n = r[rn][7];
			end
			pc = npc;
		end
		if (!halt)
		begin
			$display("model never reached a branch to self");
			errors++;
		end
	endtask

	// ========================================
	// stimulus and checking
	// ========================================
	initial
	begin
		i_instr = instr_nop;
		forever
		begin
			@(posedge clk);
			#1;
			i_instr = prog[o_pc]; // word at the current pc
		end
	end

	always @(negedge clk)
	begin
		if (active && o_out_strobe)
		begin
			assert (exp_out.size() != 0)
			else
			begin
				$display("OUT of %h that the model never produced", o_out);
				errors++;
			end
			if (exp_out.size() != 0)
			begin
				exp_v = exp_out.pop_front();
				assert (o_out == exp_v)
				else
				begin
					$display("ERR o_out: got %h expected %h", o_out, exp_v);
					errors++;
				end
			end
		end
		if (active && o_jump)
		begin
			assert (exp_tgt.size() != 0)
			else
			begin
				$display("jump to %h that the model never took", o_pc);
				errors++;
			end
			if (exp_tgt.size() != 0)
			begin
				exp_t = exp_tgt.pop_front();
				assert (o_pc == exp_t)
				else
				begin
					$display("ERR o_pc: got %h expected %h", o_pc, exp_t);
					errors++;
				end
			end
		end
	end

	task automatic compare_hex(input string sig, input logic [15:0] got,
		input logic [15:0] want);
		assert (got == want)
		else
		begin
			$display("ERR %s: got %h expected %h", sig, got, want);
			errors++;
		end
	endtask

	// load pgm, reset the DUT and run until the final branch to self
	task automatic run_program(input string name, input bit check_reset);
		int steps;
		int err0;
		err0 = errors;
		@(posedge clk);
		#1;
		restart = 1'b1;
		@(posedge reset);
		restart = 1'b0;
		for (int i = 0; i < (1 << adr_w); i++)
			prog[i] = (i < pgm.size()) ? pgm[i] : fill_word(i);
		model_run(steps);
		budget += longint'(steps) * 4 + 40;
		@(negedge reset);
		active = 1'b1;
		if (check_reset)
		begin
			@(negedge clk);
			compare_hex("o_pc", 16'(o_pc), 16'h0000);
			compare_hex("o_jump", 16'(o_jump), 16'h0000);
			compare_hex("o_out_strobe", 16'(o_out_strobe), 16'h0000);
			compare_hex("o_out", 16'(o_out), 16'h0000);
			@(negedge clk);
			compare_hex("o_pc", 16'(o_pc), 16'h0001);
		end
		while (exp_tgt.size() != 0)
			@(posedge clk);
		active = 1'b0;
		assert (exp_out.size() == 0)
		else
		begin
			$display("%0d expected OUT values never appeared", exp_out.size());
			errors++;
		end
		tests_run++;
		if (errors == err0)
			$display("test %s: ok", name);
		else
		begin
			tests_failed++;
			$display("test %s: FAILED with %0d errors", name, errors - err0);
		end
		pgm.delete();
	endtask

	// ========================================
	// watchdog
	// ========================================
	initial
	begin
		cycles = 0;
		while (cycles <= budget)
		begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
		$display("Checks failed");
		$finish;
	end

	// ========================================
	// tests
	// ========================================
	initial
	begin
		logic [3:0] sop;
		void'($urandom(99));
		restart = 1'b0;
		active = 1'b0;
		errors = 0;
		tests_run = 0;
		tests_failed = 0;
		budget = 30; // covers the power-on reset
		@(negedge reset);

		// immediates with a SUBI that wraps past zero
		pgm = {enc_i8(op_ldi, 1, 8'h10), enc_i3(op_out, 1, 0),
			enc_i8(op_addi, 1, 8'h25), enc_i3(op_out, 1, 0),
			enc_i8(op_subi, 1, 8'h40), enc_i3(op_out, 1, 0),
			enc_i8(op_ori, 1, 8'h0f), enc_i3(op_out, 1, 0),
			enc_i8(op_andi, 1, 8'h3c), enc_i3(op_out, 1, 0),
			enc_i0(op_not, 1), enc_i3(op_out, 1, 0), enc_bf(cond_al, 8'h00)};
		run_program("immediate", 1'b0);

		// o_out and o_pc still hold the previous program's state here
		pgm.push_back(enc_bf(cond_al, 8'h00));
		run_program("reset", 1'b1);

		// each op reads the register written just before it
		pgm = {enc_i8(op_ldi, 2, 8'h0f), enc_i8(op_ldi, 3, 8'h33),
			enc_i8(op_orr, 2, 8'h03), enc_i8(op_andr, 3, 8'h02),
			enc_i8(op_addr, 2, 8'h03), enc_i8(op_subr, 3, 8'h02),
			enc_i8(op_ldi, 4, 8'h81), enc_i8(op_addr, 2, 8'h04),
			enc_i3(op_out, 2, 0), enc_i3(op_out, 3, 0), enc_bf(cond_al, 8'h00)};
		run_program("register", 1'b0);

		for (int s = 0; s < 6; s++)
		begin
			for (int k = 0; k < 4; k++)
			begin
				sop = 4'(s);
				pgm.push_back(enc_i8(op_ldi, 1, k[0] ? 8'ha5 : 8'h3c));
				if (sop[0])
				begin
					pgm.push_back(enc_i8(op_ldi, 5, 8'((s << 4) | k))); // amount in bits 1:0
					pgm.push_back(enc_i3(sop, 1, 3'd5));
				end
				else
					pgm.push_back(enc_i3(sop, 1, 3'(k)));
				pgm.push_back(enc_i3(op_out, 1, 0));
			end
		end
		pgm.push_back(enc_bf(cond_al, 8'h00));
		run_program("shift", 1'b0);

		// r7 holds the marker that only shadow words would print
		pgm = {enc_i8(op_ldi, 7, 8'hee), enc_i8(op_ldi, 0, 8'h00), enc_i0(op_test, 0),
			enc_bf(cond_nz, 8'd10), enc_bf(cond_n, 8'd10), enc_bf(cond_z, 8'd3),
			enc_i3(op_out, 7, 0), enc_i3(op_out, 7, 0),
			enc_i8(op_ldi, 1, 8'h80), enc_i0(op_test, 1), // addr 8
			enc_bf(cond_z, 8'd10), enc_bf(cond_n, 8'd6),
			enc_i3(op_out, 7, 0), enc_i3(op_out, 7, 0),
			enc_i8(op_ldi, 2, 8'h11), enc_i3(op_out, 2, 0), // addr 14 is the backward target
			enc_bf(cond_al, 8'd5), enc_i0(op_test, 1), enc_bf(cond_nz, 8'hfc),
			enc_i3(op_out, 7, 0), enc_i3(op_out, 7, 0),
			enc_i8(op_ldi, 3, 8'h05), enc_i0(op_test, 3), // addr 21
			enc_bf(cond_n, 8'd2), enc_i3(op_out, 3, 0), enc_bf(cond_al, 8'h00)};
		run_program("branch", 1'b0);

		for (int p = 0; p < 3; p++)
		begin
			for (int r = 0; r < 8; r++)
				pgm.push_back(enc_i8(op_ldi, 3'(r), 8'($urandom)));
			for (int i = 0; i < 60; i++)
			begin
				case ($urandom_range(0, 4))
					0: pgm.push_back(enc_i8(4'($urandom_range(0, 8)), 3'($urandom),
						8'($urandom)));
					1: pgm.push_back(enc_i3(4'($urandom_range(0, 5)), 3'($urandom),
						3'($urandom)));
					2: pgm.push_back(enc_i0(op_not, 3'($urandom)));
					3: pgm.push_back(enc_i0(op_test, 3'($urandom)));
					default: pgm.push_back(enc_i3(op_out, 3'($urandom), 0));
				endcase
			end
			pgm.push_back(enc_bf(cond_al, 8'h00));
			run_program($sformatf("random_%0d", p), 1'b0);
		end

		$display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, errors);
		if (tests_failed == 0 && errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// File: list.f
hdl/pat_pkg.sv
hdl/alu.sv
hdl/reg_file.sv
hdl/fetch_stage.sv
hdl/decode_stage.sv
hdl/execute_stage.sv
hdl/pat_core.sv
dv/tb_clock.sv
dv/pat_core_tb.sv

// File: run.sh
#!/bin/sh
# build and run the pat_core testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal -f list.f \
	--top-module pat_core_tb -o pat_core_sim > build.log 2>&1
if [ $? -ne 0 ]; then
	echo "build failed, see build.log"
	exit 1
fi

./obj_dir/pat_core_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -qx "All checks passed" sim.log; then
	exit 0
fi
exit 1
